/* verilog/bs_pkg.sv */
package bs_pkg;

   localparam logic [31:0] RESET_PC = 32'h0000_0000;
   localparam logic [4:0]  CNT_LAST = 5'd31;      // last bit of a 32-cycle pass

   // rv32i major opcodes
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_IMM    = 7'b0010011;
   localparam logic [6:0] OPC_REG    = 7'b0110011;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;
   localparam logic [2:0] F3_LW  = 3'b010;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   typedef enum logic [2:0] {
      op_lui, op_jal, op_branch, op_load, op_store, op_imm, op_reg, op_nop
   } opcode_e;

   typedef enum logic [2:0] {
      alu_add, alu_sub, alu_xor, alu_or, alu_and
   } alu_op_e;

   typedef enum logic [2:0] {
      st_fetch, st_decode, st_exec, st_mem, st_load
   } state_e;

   typedef struct packed {
      opcode_e    opcode;
      alu_op_e    alu_op;
      logic       op_b_imm;   // second operand is the immediate
      logic       bne;        // inverted branch sense
      logic [4:0] rd_addr;
      logic [4:0] rs1_addr;
      logic [4:0] rs2_addr;
   } dec_t;

   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic        we;
      logic        cyc;
   } bus_req_t;

   typedef struct packed {
      logic [31:0] rdt;
      logic        ack;
   } bus_rsp_t;

endpackage

/* verilog/bs_decode.sv */
`timescale 1ns/1ps

module bs_decode import bs_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  bus_rsp_t i_fetch_rsp,
   input  logic     i_mem_done,
   input  logic     i_alu_cmp,
   output dec_t     o_dec,
   output logic     o_imm,
   output logic     o_exec_en,
   output logic     o_load_en,
   output logic     o_cnt_done,
   output logic     o_fetch_go,
   output logic     o_mem_go,
   output logic     o_rd_we,
   output logic     o_take
);

   state_e      state_q, state_d;
   logic [4:0]  cnt_q;
   logic [31:0] instr_q;
   logic [31:0] imm_q;
   logic [31:0] imm_d;
   logic        boot_q;
   logic        last;
   logic        is_mem;
   logic        done_now;
   dec_t        dec;

   always_comb begin
      dec          = '0;
      dec.opcode   = op_nop;
      dec.alu_op   = alu_add;
      dec.rd_addr  = instr_q[11:7];
      dec.rs1_addr = instr_q[19:15];
      dec.rs2_addr = instr_q[24:20];
      case (instr_q[6:0])
         OPC_LUI: begin
            dec.opcode   = op_lui;
            dec.op_b_imm = 1'b1;
            dec.rs1_addr = 5'd0;   // x0 + imm
         end
         OPC_JAL: dec.opcode = op_jal;
         OPC_BRANCH: begin
            if (instr_q[14:12] == F3_BEQ || instr_q[14:12] == F3_BNE) begin
               dec.opcode = op_branch;
            end
            dec.bne = (instr_q[14:12] == F3_BNE);
         end
         OPC_LOAD:  if (instr_q[14:12] == F3_LW) dec.opcode = op_load;
         OPC_STORE: if (instr_q[14:12] == F3_LW) dec.opcode = op_store;
         OPC_IMM: begin
            dec.op_b_imm = 1'b1;
            dec.opcode   = op_imm;
            case (instr_q[14:12])
               F3_ADD:  dec.alu_op = alu_add;
               F3_XOR:  dec.alu_op = alu_xor;
               F3_OR:   dec.alu_op = alu_or;
               F3_AND:  dec.alu_op = alu_and;
               default: dec.opcode = op_nop;
            endcase
         end
         OPC_REG: begin
            dec.opcode = op_reg;
            case ({instr_q[31:25], instr_q[14:12]})
               {F7_BASE, F3_ADD}: dec.alu_op = alu_add;
               {F7_SUB, F3_ADD}:  dec.alu_op = alu_sub;
               {F7_BASE, F3_XOR}: dec.alu_op = alu_xor;
               {F7_BASE, F3_OR}:  dec.alu_op = alu_or;
               {F7_BASE, F3_AND}: dec.alu_op = alu_and;
               default:           dec.opcode = op_nop;
            endcase
         end
         default: dec.opcode = op_nop;
      endcase
   end

   always_comb begin
      case (dec.opcode)
         op_lui:    imm_d = {instr_q[31:12], 12'b0};
         op_jal:    imm_d = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                             instr_q[20], instr_q[30:21], 1'b0};
         op_branch: imm_d = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                             instr_q[30:25], instr_q[11:8], 1'b0};
         op_store:  imm_d = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
         op_load,
         op_imm:    imm_d = {{20{instr_q[31]}}, instr_q[31:20]};
         default:   imm_d = '0;
      endcase
   end

   assign last     = (cnt_q == CNT_LAST);
   assign is_mem   = (dec.opcode == op_load) || (dec.opcode == op_store);
   assign done_now = (o_exec_en & last & ~is_mem) |
                     (state_q == st_mem & i_mem_done & dec.opcode == op_store) |
                     (o_load_en & last);

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_fetch:  if (i_fetch_rsp.ack) state_d = st_decode;
         st_decode: state_d = st_exec;
         st_exec:   if (last) state_d = is_mem ? st_mem : st_fetch;
         st_mem:    if (i_mem_done) state_d = (dec.opcode == op_load) ? st_load : st_fetch;
         st_load:   if (last) state_d = st_fetch;
         default:   state_d = st_fetch;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= st_fetch;
         cnt_q   <= '0;
         boot_q  <= 1'b1;   // first fetch request after reset
      end else begin
         state_q <= state_d;
         cnt_q   <= (o_exec_en | o_load_en) ? cnt_q + 5'd1 : 5'd0;
         boot_q  <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == st_fetch && i_fetch_rsp.ack) instr_q <= i_fetch_rsp.rdt;
      if (state_q == st_decode) begin
         imm_q <= imm_d;
      end else if (o_exec_en) begin
         imm_q <= {1'b0, imm_q[31:1]};   // lsb first
      end
   end

   assign o_dec      = dec;
   assign o_imm      = imm_q[0];
   assign o_exec_en  = (state_q == st_exec);
   assign o_load_en  = (state_q == st_load);
   assign o_cnt_done = (o_exec_en | o_load_en) & last;
   assign o_fetch_go = boot_q | done_now;
   assign o_mem_go   = o_exec_en & last & is_mem;
   assign o_take     = o_exec_en & o_cnt_done & (dec.opcode == op_branch) &
                       (i_alu_cmp ^ dec.bne);
   assign o_rd_we    = (dec.rd_addr != 5'd0) &
                       ((o_exec_en & (dec.opcode == op_lui || dec.opcode == op_jal ||
                                      dec.opcode == op_imm || dec.opcode == op_reg)) |
                        (o_load_en & dec.opcode == op_load));

endmodule

/* verilog/bs_ctrl.sv */
`timescale 1ns/1ps

module bs_ctrl import bs_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  dec_t     i_dec,
   input  logic     i_imm,
   input  logic     i_exec_en,
   input  logic     i_cnt_done,
   input  logic     i_take,
   input  logic     i_fetch_go,
   input  bus_rsp_t i_fetch_rsp,
   output logic     o_rd,
   output bus_req_t o_fetch_req
);

   logic [31:0] pc_q;
   logic [31:0] poff_q;
   logic [4:0]  cnt_q;
   logic        c4_q;
   logic        coff_q;
   logic        cyc_q;
   logic        four_bit;
   logic        p4_bit;
   logic        off_bit;
   logic        jump;

   // pc_q rotates through the pass, bit 0 is the current pc bit
   assign four_bit = (cnt_q == 5'd2);
   assign p4_bit   = pc_q[0] ^ four_bit ^ c4_q;
   assign off_bit  = pc_q[0] ^ i_imm ^ coff_q;
   assign jump     = i_take | (i_dec.opcode == op_jal);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_q   <= RESET_PC;
         cnt_q  <= '0;
         c4_q   <= 1'b0;
         coff_q <= 1'b0;
         cyc_q  <= 1'b0;
      end else begin
         cnt_q <= i_exec_en ? cnt_q + 5'd1 : 5'd0;
         if (i_exec_en) begin
            c4_q   <= (pc_q[0] & four_bit) | (c4_q & (pc_q[0] ^ four_bit));
            coff_q <= (pc_q[0] & i_imm) | (coff_q & (pc_q[0] ^ i_imm));
            if (i_cnt_done && jump) begin
               pc_q <= {off_bit, poff_q[31:1]};
            end else begin
               pc_q <= {p4_bit, pc_q[31:1]};   // ends up as pc+4
            end
         end else begin
            c4_q   <= 1'b0;
            coff_q <= 1'b0;
         end
         if (i_fetch_rsp.ack) begin
            cyc_q <= 1'b0;
         end else if (i_fetch_go) begin
            cyc_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_exec_en) poff_q <= {off_bit, poff_q[31:1]};
   end

   assign o_rd            = p4_bit;   // link address for jal
   assign o_fetch_req.adr = pc_q;
   assign o_fetch_req.dat = '0;
   assign o_fetch_req.we  = 1'b0;
   assign o_fetch_req.cyc = cyc_q;

endmodule

/* verilog/bs_alu.sv */
`timescale 1ns/1ps

module bs_alu import bs_pkg::*; (
   input  logic clk,
   input  logic i_rst_n,
   input  dec_t i_dec,
   input  logic i_exec_en,
   input  logic i_rs1,
   input  logic i_op_b,
   output logic o_rd,
   output logic o_cmp
);

   logic carry_q;
   logic eq_q;
   logic is_sub;
   logic b;
   logic sum;
   logic carry_d;
   logic bit_eq;

   assign is_sub  = (i_dec.alu_op == alu_sub);
   assign b       = i_op_b ^ is_sub;   // invert for two's complement subtract
   assign sum     = i_rs1 ^ b ^ carry_q;
   assign carry_d = (i_rs1 & b) | (carry_q & (i_rs1 ^ b));
   assign bit_eq  = ~(i_rs1 ^ i_op_b);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b1;
      end else if (i_exec_en) begin
         carry_q <= carry_d;
         eq_q    <= eq_q & bit_eq;
      end else begin
         carry_q <= is_sub;   // seeded before the pass starts
         eq_q    <= 1'b1;
      end
   end

   always_comb begin
      case (i_dec.alu_op)
         alu_add,
         alu_sub: o_rd = sum;
         alu_xor: o_rd = i_rs1 ^ i_op_b;
         alu_or:  o_rd = i_rs1 | i_op_b;
         alu_and: o_rd = i_rs1 & i_op_b;
         default: o_rd = sum;
      endcase
   end

   // valid on the last bit of the pass
   assign o_cmp = eq_q & bit_eq;

endmodule

/* verilog/bs_regfile.sv */
`timescale 1ns/1ps

module bs_regfile import bs_pkg::*; (
   input  logic clk,
   input  dec_t i_dec,
   input  logic i_exec_en,
   input  logic i_load_en,
   input  logic i_rd_we,
   input  logic i_rd,
   output logic o_rs1,
   output logic o_rs2
);

   logic [31:0] regs [1:31];
   logic [4:0]  cnt_q;
   logic        active;
   logic        rs1_bit;
   logic        rs2_bit;

   assign active = i_exec_en | i_load_en;

   // bit index follows the decoder pass, idle value is 0
   always_ff @(posedge clk) begin
      cnt_q <= active ? cnt_q + 5'd1 : 5'd0;
   end

   always_ff @(posedge clk) begin
      if (i_rd_we && i_dec.rd_addr != 5'd0) begin
         regs[i_dec.rd_addr][cnt_q] <= i_rd;
      end
   end

   always_comb begin
      rs1_bit = 1'b0;
      rs2_bit = 1'b0;
      if (i_dec.rs1_addr != 5'd0) rs1_bit = regs[i_dec.rs1_addr][cnt_q];
      if (i_dec.rs2_addr != 5'd0) rs2_bit = regs[i_dec.rs2_addr][cnt_q];
   end

   assign o_rs1 = rs1_bit;   // x0 reads as zero
   assign o_rs2 = rs2_bit;

endmodule

/* verilog/bs_mem_if.sv */
`timescale 1ns/1ps

module bs_mem_if import bs_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  dec_t     i_dec,
   input  logic     i_exec_en,
   input  logic     i_load_en,
   input  logic     i_rs1,
   input  logic     i_rs2,
   input  logic     i_imm,
   input  logic     i_mem_go,
   input  bus_rsp_t i_data_rsp,
   output logic     o_rd,
   output bus_req_t o_data_req
);

   logic [31:0] adr_q;
   logic [31:0] dat_q;
   logic [31:0] ld_q;
   logic        carry_q;
   logic        cyc_q;
   logic        is_mem;
   logic        is_load;
   logic        sum;

   assign is_load = (i_dec.opcode == op_load);
   assign is_mem  = is_load | (i_dec.opcode == op_store);
   assign sum     = i_rs1 ^ i_imm ^ carry_q;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         cyc_q   <= 1'b0;
      end else begin
         carry_q <= (i_exec_en & is_mem) ?
                    ((i_rs1 & i_imm) | (carry_q & (i_rs1 ^ i_imm))) : 1'b0;
         if (i_data_rsp.ack) begin
            cyc_q <= 1'b0;
         end else if (i_mem_go) begin
            cyc_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_exec_en && is_mem) begin
         adr_q <= {sum, adr_q[31:1]};     // rs1 + imm, lsb first
         dat_q <= {i_rs2, dat_q[31:1]};
      end
      if (i_data_rsp.ack && is_load) begin
         ld_q <= i_data_rsp.rdt;
      end else if (i_load_en) begin
         ld_q <= {1'b0, ld_q[31:1]};
      end
   end

   assign o_rd           = ld_q[0];
   assign o_data_req.adr = adr_q;
   assign o_data_req.dat = dat_q;
   assign o_data_req.we  = (i_dec.opcode == op_store);
   assign o_data_req.cyc = cyc_q;

endmodule

/* verilog/bs_arbiter.sv */
`timescale 1ns/1ps

module bs_arbiter import bs_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  bus_req_t i_fetch_req,
   input  bus_req_t i_data_req,
   input  bus_rsp_t i_mem_rsp,
   output bus_rsp_t o_fetch_rsp,
   output bus_rsp_t o_data_rsp,
   output bus_req_t o_mem_req
);

   logic busy_q;
   logic owner_q;    // 1 when the data master holds the port
   logic sel_data;

   // idle port goes to data first, open transaction keeps its owner
   assign sel_data = busy_q ? owner_q : i_data_req.cyc;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy_q  <= 1'b0;
         owner_q <= 1'b0;
      end else if (i_mem_rsp.ack) begin
         busy_q <= 1'b0;
      end else if (o_mem_req.cyc) begin
         busy_q  <= 1'b1;
         owner_q <= sel_data;
      end
   end

   assign o_mem_req   = sel_data ? i_data_req : i_fetch_req;
   assign o_fetch_rsp = sel_data ? bus_rsp_t'('0) : i_mem_rsp;
   assign o_data_rsp  = sel_data ? i_mem_rsp : bus_rsp_t'('0);

endmodule

/* verilog/bs_top.sv */
`timescale 1ns/1ps

module bs_top import bs_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   output bus_req_t o_mem_req,
   input  bus_rsp_t i_mem_rsp
);

   dec_t     dec;
   bus_req_t fetch_req;
   bus_req_t data_req;
   bus_rsp_t fetch_rsp;
   bus_rsp_t data_rsp;
   logic     imm;
   logic     exec_en;
   logic     load_en;
   logic     cnt_done;
   logic     fetch_go;
   logic     mem_go;
   logic     rd_we;
   logic     take;
   logic     alu_cmp;
   logic     ctrl_rd;
   logic     alu_rd;
   logic     mem_rd;
   logic     rd;
   logic     rs1;
   logic     rs2;
   logic     op_b;

   always_comb begin
      case (dec.opcode)
         op_jal:  rd = ctrl_rd;
         op_load: rd = mem_rd;
         default: rd = alu_rd;   // lui goes through the adder
      endcase
   end

   assign op_b = dec.op_b_imm ? imm : rs2;

   bs_decode decode (
      .clk(clk), .i_rst_n(i_rst_n), .i_fetch_rsp(fetch_rsp),
      .i_mem_done(data_rsp.ack), .i_alu_cmp(alu_cmp), .o_dec(dec), .o_imm(imm),
      .o_exec_en(exec_en), .o_load_en(load_en), .o_cnt_done(cnt_done),
      .o_fetch_go(fetch_go), .o_mem_go(mem_go), .o_rd_we(rd_we), .o_take(take));

   bs_ctrl ctrl (
      .clk(clk), .i_rst_n(i_rst_n), .i_dec(dec), .i_imm(imm), .i_exec_en(exec_en),
      .i_cnt_done(cnt_done), .i_take(take), .i_fetch_go(fetch_go),
      .i_fetch_rsp(fetch_rsp), .o_rd(ctrl_rd), .o_fetch_req(fetch_req));

   bs_alu alu (
      .clk(clk), .i_rst_n(i_rst_n), .i_dec(dec), .i_exec_en(exec_en),
      .i_rs1(rs1), .i_op_b(op_b), .o_rd(alu_rd), .o_cmp(alu_cmp));

   bs_regfile regfile (
      .clk(clk), .i_dec(dec), .i_exec_en(exec_en), .i_load_en(load_en),
      .i_rd_we(rd_we), .i_rd(rd), .o_rs1(rs1), .o_rs2(rs2));

   bs_mem_if mem_if (
      .clk(clk), .i_rst_n(i_rst_n), .i_dec(dec), .i_exec_en(exec_en),
      .i_load_en(load_en), .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm), .i_mem_go(mem_go),
      .i_data_rsp(data_rsp), .o_rd(mem_rd), .o_data_req(data_req));

   bs_arbiter arbiter (
      .clk(clk), .i_rst_n(i_rst_n), .i_fetch_req(fetch_req), .i_data_req(data_req),
      .i_mem_rsp(i_mem_rsp), .o_fetch_rsp(fetch_rsp), .o_data_rsp(data_rsp),
      .o_mem_req(o_mem_req));

endmodule

/* testbench/bs_props.sv */
`timescale 1ns/1ps

module bs_props import bs_pkg::*; (
   input logic     clk,
   input logic     i_rst_n,
   input bus_req_t i_mem_req,
   input bus_rsp_t i_mem_rsp,
   input bus_rsp_t i_fetch_rsp,
   input bus_rsp_t i_data_rsp,
   input logic     i_fetch_cyc,
   input logic     i_data_cyc,
   input logic     i_sel_data
);

   // an open transaction keeps its request fields until ack
   hold_fields: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_req.cyc && !i_mem_rsp.ack |=>
         $stable(i_mem_req.adr) && $stable(i_mem_req.dat) && $stable(i_mem_req.we))
      else $error("request fields changed before ack");

   // an ack goes only to the master whose cyc is raised
   one_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_rsp.ack |-> (i_fetch_rsp.ack && !i_data_rsp.ack && i_fetch_cyc) ||
                        (i_data_rsp.ack && !i_fetch_rsp.ack && i_data_cyc))
      else $error("ack not routed to the requesting master alone");

   fetch_read: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_req.cyc && !i_sel_data |-> !i_mem_req.we)
      else $error("write enable on a fetch grant");

   reset_idle: assert property (@(posedge clk) !i_rst_n |=> !i_mem_req.cyc)
      else $error("cyc high after reset");

endmodule

bind bs_arbiter bs_props props_i (
   .clk(clk), .i_rst_n(i_rst_n), .i_mem_req(o_mem_req), .i_mem_rsp(i_mem_rsp),
   .i_fetch_rsp(o_fetch_rsp), .i_data_rsp(o_data_rsp), .i_fetch_cyc(i_fetch_req.cyc),
   .i_data_cyc(i_data_req.cyc), .i_sel_data(sel_data));

/* testbench/tb_bs_top.sv */
`timescale 1ns/1ps

module tb_bs_top import bs_pkg::*; ();

   localparam int  PROG_LEN  = 123;                       // 31 init, 60 random, 31 dump, halt
   localparam int  RAND_BASE = 31;
   localparam int  DUMP_BASE = 91;
   localparam int  HALT_IDX  = 122;
   localparam int  TIMEOUT   = (PROG_LEN + 10) * 150 * 40;
   localparam logic [31:0] HALT_WORD = 32'h0000_006f;      // jal x0, 0

   logic        clk;
   logic        i_rst_n;
   bus_req_t    mem_req;
   bus_rsp_t    mem_rsp;
   logic [31:0] mem [0:1023];
   logic [31:0] mmem [0:1023];
   logic [31:0] trace_q [$];
   logic [31:0] st_adr_q [$];
   logic [31:0] st_dat_q [$];
   integer      seed;
   int          errors;
   int          fetch_idx;
   int          store_idx;
   logic        pend;
   logic [1:0]  dly;

   bs_top dut_i (.clk(clk), .i_rst_n(i_rst_n), .o_mem_req(mem_req), .i_mem_rsp(mem_rsp));

   always #20 clk = ~clk;

   function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [4:0] rand_reg();
      return 5'($unsigned($random(seed)) % 32);
   endfunction

   task automatic build_program();
      int          kind;
      int          hop;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [11:0] doff;
      for (int i = 0; i < 1024; i++) mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000;
      for (int i = 512; i < 576; i++) mem[i] = $random(seed);   // data area
      for (int i = 0; i < RAND_BASE; i++) begin
         mem[i] = enc_i(12'($random(seed)), 5'd0, 3'b000, 5'(i + 1), 7'b0010011);
      end
      for (int p = RAND_BASE; p < DUMP_BASE; p++) begin
         kind = $unsigned($random(seed)) % 16;
         hop  = 1 + $unsigned($random(seed)) % (DUMP_BASE - p);   // forward targets only
         ra   = rand_reg();
         rb   = ($random(seed) & 1) ? ra : rand_reg();
         doff = 12'(-2048 + 4 * ($unsigned($random(seed)) % 64));  // wraps onto word 512
         case (kind)
            0:  mem[p] = {20'($random(seed)), rand_reg(), 7'b0110111};
            1:  mem[p] = enc_j(21'(4 * hop), rand_reg());
            2:  mem[p] = enc_b(13'(4 * hop), rb, ra, 3'b000);
            3:  mem[p] = enc_b(13'(4 * hop), rb, ra, 3'b001);
            4:  mem[p] = enc_i(doff, 5'd0, 3'b010, rand_reg(), 7'b0000011);
            5:  mem[p] = enc_s(doff, rand_reg(), 5'd0);
            6:  mem[p] = enc_i(12'($random(seed)), ra, 3'b000, rand_reg(), 7'b0010011);
            7:  mem[p] = enc_i(12'($random(seed)), ra, 3'b100, rand_reg(), 7'b0010011);
            8:  mem[p] = enc_i(12'($random(seed)), ra, 3'b110, rand_reg(), 7'b0010011);
            9:  mem[p] = enc_i(12'($random(seed)), ra, 3'b111, rand_reg(), 7'b0010011);
            10: mem[p] = enc_r(7'h00, rb, ra, 3'b000, rand_reg());
            11: mem[p] = enc_r(7'h20, rb, ra, 3'b000, rand_reg());
            12: mem[p] = enc_r(7'h00, rb, ra, 3'b100, rand_reg());
            13: mem[p] = enc_r(7'h00, rb, ra, 3'b110, rand_reg());
            14: mem[p] = enc_r(7'h00, rb, ra, 3'b111, rand_reg());
            default: mem[p] = enc_i(12'd3, ra, 3'b001, rand_reg(), 7'b0010011);  // slli, a no-op
         endcase
      end
      for (int i = 1; i < 32; i++) begin
         mem[DUMP_BASE + i - 1] = enc_s(12'(-1024 + 4 * (i - 1)), 5'(i), 5'd0);  // word 768 on
      end
      mem[HALT_IDX] = HALT_WORD;
      for (int i = 0; i < 1024; i++) mmem[i] = mem[i];
   endtask

   // reference model of the instruction set, run on its own copy of memory
   task automatic run_model();
      logic [31:0] x [0:31];
      logic [31:0] pc;
      logic [31:0] npc;
      logic [31:0] ins;
      logic [31:0] res;
      logic [31:0] a;
      logic [31:0] immi;
      logic [31:0] imms;
      logic [31:0] immb;
      logic [31:0] immj;
      logic        wr;
      for (int i = 0; i < 32; i++) x[i] = '0;
      pc = RESET_PC;
      for (int step = 0; step < 1000; step++) begin
         ins  = mmem[pc[11:2]];
         trace_q.push_back(pc);
         if (ins == HALT_WORD) break;
         immi = {{20{ins[31]}}, ins[31:20]};
         imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         immb = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         immj = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         npc  = pc + 4;
         wr   = 1'b0;
         res  = '0;
         case (ins[6:0])
            7'b0110111: begin res = {ins[31:12], 12'b0}; wr = 1'b1; end
            7'b1101111: begin res = pc + 4; wr = 1'b1; npc = pc + immj; end
            7'b1100011: begin
               if (ins[14:12] == 3'b000 && x[ins[19:15]] == x[ins[24:20]]) npc = pc + immb;
               if (ins[14:12] == 3'b001 && x[ins[19:15]] != x[ins[24:20]]) npc = pc + immb;
            end
            7'b0000011: if (ins[14:12] == 3'b010) begin
               a   = x[ins[19:15]] + immi;
               res = mmem[a[11:2]];
               wr  = 1'b1;
            end
            7'b0100011: if (ins[14:12] == 3'b010) begin
               a = x[ins[19:15]] + imms;
               mmem[a[11:2]] = x[ins[24:20]];
               st_adr_q.push_back(a);
               st_dat_q.push_back(x[ins[24:20]]);
            end
            7'b0010011: begin
               wr = 1'b1;
               case (ins[14:12])
                  3'b000:  res = x[ins[19:15]] + immi;
                  3'b100:  res = x[ins[19:15]] ^ immi;
                  3'b110:  res = x[ins[19:15]] | immi;
                  3'b111:  res = x[ins[19:15]] & immi;
                  default: wr = 1'b0;
               endcase
            end
            7'b0110011: begin
               wr = 1'b1;
               case ({ins[31:25], ins[14:12]})
                  10'h000: res = x[ins[19:15]] + x[ins[24:20]];
                  10'h100: res = x[ins[19:15]] - x[ins[24:20]];
                  10'h004: res = x[ins[19:15]] ^ x[ins[24:20]];
                  10'h006: res = x[ins[19:15]] | x[ins[24:20]];
                  10'h007: res = x[ins[19:15]] & x[ins[24:20]];
                  default: wr = 1'b0;
               endcase
            end
            default: ;
         endcase
         if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
         pc = npc;
      end
   endtask

   // fetches have low addresses, data accesses sit in the wrapped top of the space
   task automatic check_xfer();
      logic [31:0] exp_pc;
      if (mem_req.we) begin
         assert (store_idx < st_adr_q.size()) else begin
            errors++;
            $display("unexpected extra store to address %h", mem_req.adr);
         end
         if (store_idx < st_adr_q.size()) begin
            assert (mem_req.adr == st_adr_q[store_idx]) else begin
               errors++;
               $display("Mismatch adr: got %h expected %h", mem_req.adr, st_adr_q[store_idx]);
            end
            assert (mem_req.dat == st_dat_q[store_idx]) else begin
               errors++;
               $display("Mismatch dat: got %h expected %h", mem_req.dat, st_dat_q[store_idx]);
            end
         end
         store_idx++;
      end else if (!mem_req.adr[31]) begin
         if (fetch_idx == 0) begin
            assert (mem_req.adr == RESET_PC) else begin
               errors++;
               $display("Mismatch adr: first fetch %h expected %h", mem_req.adr, RESET_PC);
            end
         end
         exp_pc = trace_q[(fetch_idx < trace_q.size()) ? fetch_idx : trace_q.size() - 1];
         assert (mem_req.adr == exp_pc) else begin
            errors++;
            $display("Mismatch adr: fetch %0d got %h expected %h", fetch_idx, mem_req.adr,
                     exp_pc);
         end
         fetch_idx++;
      end
   endtask

   task automatic check_idle(input string phase);
      assert (!mem_req.cyc) else begin
         errors++;
         $display("Mismatch cyc %s: got %h expected %h", phase, mem_req.cyc, 1'b0);
      end
   endtask

   // memory with an ack delay of 0 to 3 extra cycles
   always @(posedge clk) begin
      mem_rsp.ack <= 1'b0;
      if (!i_rst_n) begin
         pend <= 1'b0;
      end else if (mem_req.cyc && !mem_rsp.ack) begin
         if (!pend) begin
            pend <= 1'b1;
            dly  <= 2'($random(seed));
         end else if (dly != 2'd0) begin
            dly <= dly - 2'd1;
         end else begin
            pend        <= 1'b0;
            mem_rsp.ack <= 1'b1;
            mem_rsp.rdt <= mem[mem_req.adr[11:2]];
            if (mem_req.we) mem[mem_req.adr[11:2]] <= mem_req.dat;
            check_xfer();
         end
      end
   end

   initial begin
      #(TIMEOUT * 1ns);
      $display("timeout: the program never reached the halt loop");
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      clk       = 1'b0;
      i_rst_n   = 1'b0;
      mem_rsp   = '0;
      pend      = 1'b0;
      dly       = '0;
      errors    = 0;
      fetch_idx = 0;
      store_idx = 0;
      seed      = 32'h9f6;
      build_program();
      run_model();
      @(negedge clk);
      check_idle("during reset");
      @(posedge clk);
      i_rst_n <= 1'b1;
      @(negedge clk);
      check_idle("after reset");
      while (fetch_idx < trace_q.size()) @(posedge clk);
      repeat (10) @(posedge clk);
      assert (store_idx == st_adr_q.size()) else begin
         errors++;
         $display("Mismatch store count: got %h expected %h", store_idx, st_adr_q.size());
      end
      $display("errors %0d, fetches %0d, stores %0d", errors, fetch_idx, store_idx);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* bs_top.f */
verilog/bs_pkg.sv
verilog/bs_decode.sv
verilog/bs_ctrl.sv
verilog/bs_alu.sv
verilog/bs_regfile.sv
verilog/bs_mem_if.sv
verilog/bs_arbiter.sv
verilog/bs_top.sv
testbench/bs_props.sv
testbench/tb_bs_top.sv
